//--- design/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// ==========================================================================
// Sprite scan sizing
// ==========================================================================

// Entries in object attribute memory.
`define OAM_ENTRIES 40

// Sprites kept per display line.
`define SPRITES_PER_LINE 10

// OAM Y holds the screen line plus this offset.
`define SPRITE_Y_OFFSET 16

`endif

//--- design/oam_pkg.sv
`include "ppu_settings.svh"

package oam_pkg;

	// Entry number inside OAM.
	typedef logic [$clog2(`OAM_ENTRIES)-1:0] oam_index_t;

	// Screen line, pixel column or raw OAM position.
	typedef logic [7:0] coord_t;

	// Position part of one OAM entry.
	typedef struct packed {
		coord_t y;
		coord_t x;
	} oam_entry_t;

endpackage

//--- design/sprite_pkg.sv
`include "ppu_settings.svh"

package sprite_pkg;

	// Row of the sprite that falls on the current line.
	typedef logic [3:0] sprite_row_t;

	// One bit per slot of the line store.
	typedef logic [`SPRITES_PER_LINE-1:0] slot_mask_t;

	// Sprite found on the line, on its way into the store.
	typedef struct packed {
		oam_pkg::oam_index_t idx;
		sprite_row_t         row;
		oam_pkg::coord_t     x;
	} sprite_cand_t;

	// Result of a pixel lookup.
	typedef struct packed {
		oam_pkg::oam_index_t idx;
		sprite_row_t         row;
	} sprite_hit_t;

	// Line phases.
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SCAN,
		ST_DRAIN,
		ST_RENDER
	} scan_state_t;

endpackage

//--- design/oam_scan_fsm.sv
`timescale 1ns/1ps

module oam_scan_fsm (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic line_start_i,
	input  logic last_entry_i,
	output logic scan_en_o,
	output logic clear_o,
	output logic render_o,
	output logic scan_done_o
);

	sprite_pkg::scan_state_t state_q;
	sprite_pkg::scan_state_t state_d;
	logic                    scan_done_q;

	// ======================================================================
	// Next state
	// ======================================================================

	always_comb begin
		state_d = state_q;
		case (state_q)
			sprite_pkg::ST_IDLE: begin
				state_d = sprite_pkg::ST_IDLE;
			end
			sprite_pkg::ST_SCAN: begin
				if (last_entry_i) begin
					state_d = sprite_pkg::ST_DRAIN;
				end
			end
			// Last candidate is written during this cycle.
			sprite_pkg::ST_DRAIN: begin
				state_d = sprite_pkg::ST_RENDER;
			end
			sprite_pkg::ST_RENDER: begin
				state_d = sprite_pkg::ST_RENDER;
			end
			default: begin
				state_d = sprite_pkg::ST_IDLE;
			end
		endcase
		// A new line always restarts the scan.
		if (line_start_i) begin
			state_d = sprite_pkg::ST_SCAN;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= sprite_pkg::ST_IDLE;
			scan_done_q <= 1'b0;
		end else begin
			state_q     <= state_d;
			scan_done_q <= (state_q == sprite_pkg::ST_DRAIN) && !line_start_i;
		end
	end

	// Held off in the restart cycle so no stale entry reaches the fresh store.
	assign scan_en_o   = (state_q == sprite_pkg::ST_SCAN) && !line_start_i;
	assign clear_o     = line_start_i;
	assign render_o    = (state_q == sprite_pkg::ST_RENDER);
	assign scan_done_o = scan_done_q;

	a_done_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		scan_done_o |=> !scan_done_o)
		else $error("scan_done held longer than one cycle");

endmodule

//--- design/oam_scan_counter.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module oam_scan_counter (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                clear_i,
	input  logic                scan_en_i,
	output oam_pkg::oam_index_t entry_o,
	output logic                last_entry_o
);

	oam_pkg::oam_index_t entry_q;

	// Entry address, starts over at every new line.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			entry_q <= '0;
		end else if (clear_i) begin
			entry_q <= '0;
		end else if (scan_en_i && !last_entry_o) begin
			entry_q <= entry_q + 1'b1;
		end
	end

	assign entry_o      = entry_q;
	assign last_entry_o = (entry_q == oam_pkg::oam_index_t'(`OAM_ENTRIES - 1));

	a_entry_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		entry_q <= oam_pkg::oam_index_t'(`OAM_ENTRIES - 1))
		else $error("OAM address past last entry");

endmodule

//--- design/sprite_line_matcher.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module sprite_line_matcher (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    scan_en_i,
	input  logic                    tall_i,
	input  oam_pkg::coord_t         ly_i,
	input  oam_pkg::oam_index_t     entry_i,
	input  oam_pkg::oam_entry_t     oam_i,
	output logic                    cand_wr_o,
	output sprite_pkg::sprite_cand_t cand_o
);

	oam_pkg::coord_t          diff;
	logic                     on_line;
	logic                     cand_wr_q;
	sprite_pkg::sprite_cand_t cand_q;

	// Distance from the sprite top, wraps in 8 bits above the sprite.
	assign diff = ly_i + oam_pkg::coord_t'(`SPRITE_Y_OFFSET) - oam_i.y;

	// 8x16 mode doubles the height.
	assign on_line = tall_i ? (diff < 8'd16) : (diff < 8'd8);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cand_wr_q <= 1'b0;
		end else begin
			cand_wr_q <= scan_en_i && on_line;
		end
	end

	always_ff @(posedge clk_i) begin
		cand_q.idx <= entry_i;
		cand_q.row <= sprite_pkg::sprite_row_t'(diff[3:0]);
		cand_q.x   <= oam_i.x;
	end

	assign cand_wr_o = cand_wr_q;
	assign cand_o    = cand_q;

endmodule

//--- design/sprite_store.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module sprite_store (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     clear_i,
	input  logic                     cand_wr_i,
	input  sprite_pkg::sprite_cand_t cand_i,
	input  logic                     lookup_i,
	input  logic                     match_any_i,
	input  logic [3:0]               match_slot_i,
	output sprite_pkg::slot_mask_t   slot_wr_o,
	output sprite_pkg::slot_mask_t   filled_o,
	output oam_pkg::coord_t          x_o,
	output logic [3:0]               count_o,
	output logic                     hit_valid_o,
	output logic                     hit_found_o,
	output sprite_pkg::sprite_hit_t  hit_o
);

	sprite_pkg::sprite_hit_t slots_q [`SPRITES_PER_LINE];
	logic [3:0]              count_q;
	logic                    wr_en;
	logic                    hit_valid_q;
	logic                    hit_found_q;
	sprite_pkg::sprite_hit_t hit_q;

	// ======================================================================
	// Slot allocation
	// ======================================================================

	// Later candidates are dropped once all slots are taken.
	assign wr_en = cand_wr_i && !clear_i && (count_q < 4'(`SPRITES_PER_LINE));

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			count_q <= '0;
		end else if (clear_i) begin
			count_q <= '0;
		end else if (wr_en) begin
			count_q <= count_q + 4'd1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			slots_q[count_q].idx <= cand_i.idx;
			slots_q[count_q].row <= cand_i.row;
		end
	end

	assign slot_wr_o = wr_en ? (sprite_pkg::slot_mask_t'(1) << count_q) : '0;
	assign x_o       = cand_i.x;
	assign count_o   = count_q;

	always_comb begin
		for (int i = 0; i < `SPRITES_PER_LINE; i++) begin
			filled_o[i] = (i < count_q);
		end
	end

	// ======================================================================
	// Lookup result
	// ======================================================================

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hit_valid_q <= 1'b0;
			hit_found_q <= 1'b0;
		end else begin
			hit_valid_q <= lookup_i;
			hit_found_q <= lookup_i && match_any_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (lookup_i && match_slot_i < 4'(`SPRITES_PER_LINE)) begin
			hit_q <= slots_q[match_slot_i];
		end
	end

	assign hit_valid_o = hit_valid_q;
	assign hit_found_o = hit_found_q;
	assign hit_o       = hit_q;

	a_count_cap : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		count_q <= 4'(`SPRITES_PER_LINE))
		else $error("sprite store count overflow");

endmodule

//--- design/sprite_x_match.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module sprite_x_match (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  sprite_pkg::slot_mask_t slot_wr_i,
	input  sprite_pkg::slot_mask_t filled_i,
	input  oam_pkg::coord_t        x_i,
	input  oam_pkg::coord_t        px_x_i,
	output logic [3:0]             match_slot_o,
	output logic                   match_any_o
);

	oam_pkg::coord_t        x_q [`SPRITES_PER_LINE];
	sprite_pkg::slot_mask_t hit_mask;

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < `SPRITES_PER_LINE; i++) begin
			if (slot_wr_i[i]) begin
				x_q[i] <= x_i;
			end
		end
	end

	// Empty slots never match.
	always_comb begin
		for (int i = 0; i < `SPRITES_PER_LINE; i++) begin
			hit_mask[i] = filled_i[i] && (x_q[i] == px_x_i);
		end
	end

	// Lowest slot wins, which is also the lowest OAM index.
	always_comb begin
		match_slot_o = '0;
		for (int i = `SPRITES_PER_LINE - 1; i >= 0; i--) begin
			if (hit_mask[i]) begin
				match_slot_o = 4'(i);
			end
		end
	end

	assign match_any_o = |hit_mask;

	// Store only ever allocates a slot that was still empty.
	a_wr_free_slot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0(slot_wr_i) && ((slot_wr_i & filled_i) == '0))
		else $error("X register write to an occupied slot");

endmodule

//--- design/sprite_scan_top.sv
`timescale 1ns/1ps

module sprite_scan_top (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    line_start_i,
	input  logic                    tall_i,
	input  logic                    px_valid_i,
	input  oam_pkg::coord_t         ly_i,
	input  oam_pkg::coord_t         px_x_i,
	input  oam_pkg::oam_entry_t     oam_entry_i,
	output oam_pkg::oam_index_t     oam_addr_o,
	output logic                    scan_done_o,
	output logic                    hit_valid_o,
	output logic                    sprite_hit_o,
	output logic [3:0]              sprite_count_o,
	output sprite_pkg::sprite_hit_t hit_o
);

	logic                     scan_en;
	logic                     clear;
	logic                     render;
	logic                     last_entry;
	logic                     lookup;
	logic                     cand_wr;
	sprite_pkg::sprite_cand_t cand;
	sprite_pkg::slot_mask_t   slot_wr;
	sprite_pkg::slot_mask_t   filled;
	oam_pkg::coord_t          slot_x;
	logic [3:0]               match_slot;
	logic                     match_any;

	// Pixel lookups count only while rendering.
	assign lookup = px_valid_i && render;

	oam_scan_fsm i_fsm (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.line_start_i (line_start_i),
		.last_entry_i (last_entry),
		.scan_en_o    (scan_en),
		.clear_o      (clear),
		.render_o     (render),
		.scan_done_o  (scan_done_o)
	);

	oam_scan_counter i_counter (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.clear_i      (clear),
		.scan_en_i    (scan_en),
		.entry_o      (oam_addr_o),
		.last_entry_o (last_entry)
	);

	sprite_line_matcher i_matcher (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.scan_en_i (scan_en),
		.tall_i    (tall_i),
		.ly_i      (ly_i),
		.entry_i   (oam_addr_o),
		.oam_i     (oam_entry_i),
		.cand_wr_o (cand_wr),
		.cand_o    (cand)
	);

	sprite_store i_store (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.clear_i      (clear),
		.cand_wr_i    (cand_wr),
		.cand_i       (cand),
		.lookup_i     (lookup),
		.match_any_i  (match_any),
		.match_slot_i (match_slot),
		.slot_wr_o    (slot_wr),
		.filled_o     (filled),
		.x_o          (slot_x),
		.count_o      (sprite_count_o),
		.hit_valid_o  (hit_valid_o),
		.hit_found_o  (sprite_hit_o),
		.hit_o        (hit_o)
	);

	sprite_x_match i_x_match (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.slot_wr_i    (slot_wr),
		.filled_i     (filled),
		.x_i          (slot_x),
		.px_x_i       (px_x_i),
		.match_slot_o (match_slot),
		.match_any_o  (match_any)
	);

endmodule

//--- test/sprite_scan_tb.sv
`timescale 1ns/1ps

`include "ppu_settings.svh"

module sprite_scan_tb;

	localparam int NUM_LINES      = 8;
	localparam int NUM_SWEEPS     = 7;
	localparam int TIMEOUT_CYCLES = NUM_LINES * 60 + NUM_SWEEPS * 300 + 10;

	logic                    clk_i;
	logic                    rst_n_i;
	logic                    line_start_i;
	logic                    tall_i;
	logic                    px_valid_i;
	oam_pkg::coord_t         ly_i;
	oam_pkg::coord_t         px_x_i;
	oam_pkg::oam_entry_t     oam_entry_i;
	oam_pkg::oam_index_t     oam_addr_o;
	logic                    scan_done_o;
	logic                    hit_valid_o;
	logic                    sprite_hit_o;
	logic [3:0]              sprite_count_o;
	sprite_pkg::sprite_hit_t hit_o;

	oam_pkg::oam_entry_t oam_mem [`OAM_ENTRIES];

	// Expected store contents for the current line.
	int ref_idx [`SPRITES_PER_LINE];
	int ref_row [`SPRITES_PER_LINE];
	int ref_x   [`SPRITES_PER_LINE];
	int ref_count;
	int ref_total;

	integer          seed;
	int              cycle_count;
	logic            render_exp;
	logic            exp_valid_q;
	oam_pkg::coord_t exp_px_q;

	sprite_scan_top i_dut (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.line_start_i   (line_start_i),
		.tall_i         (tall_i),
		.px_valid_i     (px_valid_i),
		.ly_i           (ly_i),
		.px_x_i         (px_x_i),
		.oam_entry_i    (oam_entry_i),
		.oam_addr_o     (oam_addr_o),
		.scan_done_o    (scan_done_o),
		.hit_valid_o    (hit_valid_o),
		.sprite_hit_o   (sprite_hit_o),
		.sprite_count_o (sprite_count_o),
		.hit_o          (hit_o)
	);

	// OAM answers in the same cycle.
	assign oam_entry_i = oam_mem[oam_addr_o];

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ==========================================================================
	// Reference model
	// ==========================================================================

	function automatic void build_reference(input logic [7:0] ly, input logic tall);
		logic [7:0] diff;
		int         height;
		height    = tall ? 16 : 8;
		ref_count = 0;
		ref_total = 0;
		for (int i = 0; i < `OAM_ENTRIES; i++) begin
			diff = ly + `SPRITE_Y_OFFSET - oam_mem[i].y;
			if (diff < height) begin
				ref_total++;
				if (ref_count < `SPRITES_PER_LINE) begin
					ref_idx[ref_count] = i;
					ref_row[ref_count] = diff[3:0];
					ref_x[ref_count]   = oam_mem[i].x;
					ref_count++;
				end
			end
		end
	endfunction

	// Position in the expected list of the first sprite at this column, or -1.
	function automatic int find_reference(input int px);
		for (int i = 0; i < ref_count; i++) begin
			if (ref_x[i] == px) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "Stopped at the first mismatch.");
		end
	endtask

	// ==========================================================================
	// Lookup checker
	// ==========================================================================

	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exp_valid_q <= 1'b0;
			exp_px_q    <= '0;
		end else begin
			exp_valid_q <= px_valid_i && render_exp;
			exp_px_q    <= px_x_i;
		end
	end

	always @(negedge clk_i) begin : compare_lookup
		int pos;
		if (rst_n_i) begin
			check_value(hit_valid_o, exp_valid_q, "hit_valid_o");
			if (exp_valid_q) begin
				pos = find_reference(exp_px_q);
				check_value(sprite_hit_o, pos >= 0,
					$sformatf("sprite_hit_o at column %0d", exp_px_q));
				if (pos >= 0) begin
					check_value(hit_o.idx, ref_idx[pos],
						$sformatf("hit_o.idx at column %0d", exp_px_q));
					check_value(hit_o.row, ref_row[pos],
						$sformatf("hit_o.row at column %0d", exp_px_q));
				end
			end
		end
	end

	always @(posedge clk_i) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run hung and did not finish within %0d cycles", cycle_count);
			$display("CHECKS FAILED");
			$fatal(1, "Timeout.");
		end
	end

	// ==========================================================================
	// Stimulus
	// ==========================================================================

	task automatic run_line(input logic [7:0] ly, input logic tall);
		int cycles;
		build_reference(ly, tall);
		@(negedge clk_i);
		ly_i         = ly;
		tall_i       = tall;
		line_start_i = 1'b1;
		render_exp   = 1'b0;
		cycles       = 0;
		do begin
			@(negedge clk_i);
			line_start_i = 1'b0;
			cycles++;
			// Entry k is on the OAM port in scan cycle k plus one.
			if (cycles <= `OAM_ENTRIES) begin
				check_value(oam_addr_o, cycles - 1,
					$sformatf("oam_addr_o in scan cycle %0d on line %0d", cycles, ly));
			end
		end while (!scan_done_o && cycles < 100);
		check_value(cycles, 42, $sformatf("scan_done_o delay on line %0d", ly));
		check_value(sprite_count_o, ref_count, $sformatf("sprite_count_o on line %0d", ly));
		render_exp = 1'b1;
	endtask

	// Starts a scan and breaks into it with the next line_start_i.
	// Pixel requests during the scan must not produce lookups.
	task automatic start_aborted(input logic [7:0] ly, input logic tall, input int cycles);
		@(negedge clk_i);
		ly_i         = ly;
		tall_i       = tall;
		line_start_i = 1'b1;
		render_exp   = 1'b0;
		repeat (cycles) begin
			@(negedge clk_i);
			line_start_i = 1'b0;
			px_valid_i   = 1'b1;
			px_x_i       = oam_mem[0].x;
			check_value(scan_done_o, 1'b0, "scan_done_o during the aborted scan");
		end
		px_valid_i = 1'b0;
	endtask

	task automatic sweep_columns();
		for (int c = 0; c < 256; c++) begin
			@(negedge clk_i);
			px_valid_i = 1'b1;
			px_x_i     = c;
		end
		@(negedge clk_i);
		px_valid_i = 1'b0;
		@(negedge clk_i);
	endtask

	initial begin
		logic [7:0] line_ly   [6];
		logic       line_tall [6];
		rst_n_i      = 1'b0;
		line_start_i = 1'b0;
		tall_i       = 1'b0;
		px_valid_i   = 1'b0;
		ly_i         = '0;
		px_x_i       = '0;
		render_exp   = 1'b0;
		cycle_count  = 0;
		seed         = 32'h2506;
		line_ly      = '{8'd56, 8'd60, 8'd64, 8'd70, 8'd20, 8'd40};
		line_tall    = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};

		// Y near lines 53 to 76 so some lines hold more than ten sprites.
		for (int i = 0; i < `OAM_ENTRIES; i++) begin
			oam_mem[i].y = 76 - ({$random(seed)} % 24);
			oam_mem[i].x = {$random(seed)} % 32;
		end

		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		@(negedge clk_i);
		check_value(scan_done_o, 1'b0, "scan_done_o after reset");
		check_value(hit_valid_o, 1'b0, "hit_valid_o after reset");
		check_value(sprite_hit_o, 1'b0, "sprite_hit_o after reset");
		check_value(sprite_count_o, 0, "sprite_count_o after reset");

		for (int n = 0; n < 6; n++) begin
			run_line(line_ly[n], line_tall[n]);
			if (n == 1) begin
				check_value(ref_total > `SPRITES_PER_LINE, 1'b1, "crowded line setup");
			end
			sweep_columns();
		end

		// Restart in the middle of a scan that has already stored sprites.
		start_aborted(8'd56, 1'b0, 20);
		run_line(8'd66, 1'b1);
		sweep_columns();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+design
design/oam_pkg.sv
design/sprite_pkg.sv
design/oam_scan_fsm.sv
design/oam_scan_counter.sv
design/sprite_line_matcher.sv
design/sprite_store.sv
design/sprite_x_match.sv
design/sprite_scan_top.sv
test/sprite_scan_tb.sv
